//--- common/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // cache geometry
    localparam int way_num     = 4;
    localparam int line_words  = 4;
    localparam int set_num     = 16;
    localparam int tag_width   = 24;
    localparam int index_width = 4;
    localparam int word_width  = 2;

    // byte address split into its cache fields
    typedef struct packed {
        logic [tag_width-1:0]   tag;
        logic [index_width-1:0] index;
        logic [word_width-1:0]  word;
        logic [1:0]             byte_off;   // always zero for word accesses
    } dcache_addr_fields_t;

    // raw view for the memory port, field view for lookup
    typedef union packed {
        logic [31:0]         raw;
        dcache_addr_fields_t f;
    } dcache_addr_u;

    typedef enum logic [2:0] {
        s_idle,
        s_lookup,
        s_writeback,
        s_refill,
        s_uncached
    } cache_state_e;

endpackage

`default_nettype wire

//--- d_cache/d_tag_ram.sv
`timescale 1ns/1ns
`default_nettype none

module d_tag_ram (
    input  wire                               clk,
    input  wire                               we,
    input  wire [dcache_pkg::index_width-1:0] waddr,
    input  wire [dcache_pkg::tag_width-1:0]   wtag,
    input  wire                               re,
    input  wire [dcache_pkg::index_width-1:0] raddr,
    output logic [dcache_pkg::tag_width-1:0]  rtag
);
    import dcache_pkg::*;

    logic [tag_width-1:0] mem [set_num];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wtag;
        end
    end

    // write-first when both ports hit the same set
    always_ff @(posedge clk) begin
        if (re) begin
            rtag <= (we && waddr == raddr) ? wtag : mem[raddr];
        end
    end

endmodule

`default_nettype wire

//--- d_cache/d_data_bank.sv
`timescale 1ns/1ns
`default_nettype none

module d_data_bank (
    input  wire                                     clk,
    input  wire [3:0]                               wbe,
    input  wire [dcache_pkg::word_width-1:0]        wword,
    input  wire [dcache_pkg::index_width-1:0]       waddr,
    input  wire [31:0]                              wdata,
    input  wire                                     re,
    input  wire [dcache_pkg::index_width-1:0]       raddr,
    output logic [dcache_pkg::line_words*32-1:0]    rline
);
    import dcache_pkg::*;

    logic [line_words-1:0][31:0] mem [set_num];
    logic [line_words-1:0][31:0] rd_line;   // read data after bypass

    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (wbe[b]) begin
                mem[waddr][wword][b*8 +: 8] <= wdata[b*8 +: 8];
            end
        end
    end

    // bytes written this cycle show up in the registered line
    always_comb begin
        rd_line = mem[raddr];
        for (int b = 0; b < 4; b++) begin
            if (wbe[b] && waddr == raddr) begin
                rd_line[wword][b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (re) begin
            rline <= rd_line;
        end
    end

endmodule

`default_nettype wire

//--- d_cache/plru_tree.sv
`timescale 1ns/1ns
`default_nettype none

module plru_tree (
    input  wire                               clk,
    input  wire                               rst,
    input  wire [dcache_pkg::index_width-1:0] index,
    input  wire                               touch,
    input  wire [1:0]                         touch_way,
    output logic [1:0]                        victim
);
    import dcache_pkg::*;

    // bit 0 picks the half, bit 1 and bit 2 pick inside each half
    logic [2:0] tree [set_num];
    logic [2:0] cur;

    assign cur    = tree[index];
    assign victim = {cur[0], cur[0] ? cur[2] : cur[1]};

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < set_num; s++) begin
                tree[s] <= '0;
            end
        end else if (touch) begin
            tree[index][0] <= ~touch_way[1];    // point away from the used half
            if (touch_way[1]) begin
                tree[index][2] <= ~touch_way[0];
            end else begin
                tree[index][1] <= ~touch_way[0];
            end
        end
    end

endmodule

`default_nettype wire

//--- d_cache/d_cache.sv
`timescale 1ns/1ns
`default_nettype none

module d_cache (
    input  wire         clk,
    input  wire         rst,
    // execute stage
    input  wire         mem_req_e,
    input  wire [31:0]  mem_addr_e,
    // memory stage
    input  wire         data_en,
    input  wire [31:0]  data_addr,
    input  wire [3:0]   data_wen,
    input  wire [31:0]  data_wdata,
    input  wire         no_cache,
    output logic [31:0] data_rdata,
    output logic        stall,
    // read channels
    output logic [31:0] araddr,
    output logic [7:0]  arlen,
    output logic        arvalid,
    input  wire         arready,
    input  wire [31:0]  rdata,
    input  wire         rvalid,
    input  wire         rlast,
    output logic        rready,
    // write channels
    output logic [31:0] awaddr,
    output logic [7:0]  awlen,
    output logic        awvalid,
    input  wire         awready,
    output logic [31:0] wdata,
    output logic [3:0]  wstrb,
    output logic        wlast,
    output logic        wvalid,
    input  wire         wready,
    input  wire         bvalid,
    output logic        bready
);
    import dcache_pkg::*;

    cache_state_e state;
    dcache_addr_u req_addr, exe_addr, wb_addr, rf_addr;

    logic [set_num-1:0][way_num-1:0] valid_q, dirty_q;
    logic [tag_width-1:0]      rtag [way_num];
    logic [line_words*32-1:0]  rline [way_num];
    logic [3:0]                way_wbe [way_num];
    logic [way_num-1:0]        way_tag_we, hit_mask;
    logic [1:0]                hit_way, victim, victim_q;
    logic [word_width-1:0]     bcnt, wr_word;
    logic [31:0]               wr_data, refill_word, hit_word, saved_rdata, byte_mask;
    logic hit, is_store, access, hit_acc, store_hit;
    logic ram_re, r_beat, refill_end, victim_dirty, uncached;

    assign req_addr.raw = data_addr;
    assign exe_addr.raw = mem_addr_e;

    assign is_store  = |data_wen;
    assign access    = (state == s_lookup) && data_en;
    assign hit_acc   = access && !no_cache && hit;
    assign store_hit = hit_acc && is_store;
    assign uncached  = (state == s_uncached);

    // tag compare against the set read in the execute stage
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < way_num; w++) begin
            hit_mask[w] = valid_q[req_addr.f.index][w] && (rtag[w] == req_addr.f.tag);
            if (hit_mask[w]) begin
                hit_way = 2'(w);
            end
        end
    end

    assign hit      = |hit_mask;
    assign hit_word = rline[hit_way][req_addr.f.word*32 +: 32];
    assign victim_dirty = valid_q[req_addr.f.index][victim] && dirty_q[req_addr.f.index][victim];

    assign stall = (state == s_writeback) || (state == s_refill) || uncached ||
                   (access && (no_cache || !hit));
    assign data_rdata = (state == s_lookup) ? hit_word : saved_rdata;

    // RAMs only advance when the pipeline does, so the set stays put during a miss
    assign ram_re = mem_req_e && !stall;

    assign r_beat     = rvalid && rready;
    assign refill_end = (state == s_refill) && r_beat && rlast;

    assign byte_mask = {{8{data_wen[3]}}, {8{data_wen[2]}}, {8{data_wen[1]}}, {8{data_wen[0]}}};
    assign refill_word = (is_store && bcnt == req_addr.f.word) ?
                         ((rdata & ~byte_mask) | (data_wdata & byte_mask)) : rdata;

    // shared bank write port, store hit or refill beat
    assign wr_word = store_hit ? req_addr.f.word : bcnt;
    assign wr_data = store_hit ? data_wdata : refill_word;

    always_comb begin
        for (int w = 0; w < way_num; w++) begin
            way_wbe[w] = '0;
            if (store_hit && hit_mask[w]) begin
                way_wbe[w] = data_wen;
            end else if (state == s_refill && r_beat && victim_q == 2'(w)) begin
                way_wbe[w] = 4'hf;
            end
            way_tag_we[w] = refill_end && (victim_q == 2'(w));
        end
    end

    // line addresses built through the field view
    always_comb begin
        wb_addr.raw     = '0;
        wb_addr.f.tag   = rtag[victim_q];
        wb_addr.f.index = req_addr.f.index;
        rf_addr.raw     = '0;
        rf_addr.f.tag   = req_addr.f.tag;
        rf_addr.f.index = req_addr.f.index;
    end

    assign araddr = uncached ? data_addr : rf_addr.raw;
    assign arlen  = uncached ? 8'd0 : 8'(line_words - 1);
    assign rready = (state == s_refill) || (uncached && !is_store);
    assign awaddr = uncached ? data_addr : wb_addr.raw;
    assign awlen  = uncached ? 8'd0 : 8'(line_words - 1);
    assign wdata  = uncached ? data_wdata : rline[victim_q][bcnt*32 +: 32];
    assign wstrb  = uncached ? data_wen : 4'hf;
    assign wlast  = uncached || (bcnt == word_width'(line_words - 1));
    assign bready = (state == s_writeback) || (uncached && is_store);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= s_idle;
            arvalid <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            bcnt    <= '0;
        end else begin
            case (state)
                s_idle: begin
                    if (mem_req_e) begin
                        state <= s_lookup;
                    end
                end
                s_lookup: begin
                    if (!access || (!no_cache && hit)) begin
                        state <= mem_req_e ? s_lookup : s_idle;   // back-to-back hits
                    end else if (no_cache) begin
                        state   <= s_uncached;
                        awvalid <= is_store;
                        arvalid <= !is_store;
                    end else if (victim_dirty) begin
                        state   <= s_writeback;
                        awvalid <= 1'b1;
                    end else begin
                        state   <= s_refill;
                        arvalid <= 1'b1;
                    end
                end
                s_writeback: begin
                    if (awvalid && awready) begin
                        awvalid <= 1'b0;
                        wvalid  <= 1'b1;
                    end
                    if (wvalid && wready) begin
                        bcnt <= bcnt + 1'b1;    // wraps back to zero after the last beat
                        if (wlast) begin
                            wvalid <= 1'b0;
                        end
                    end
                    if (bvalid && bready) begin
                        state   <= s_refill;
                        arvalid <= 1'b1;
                    end
                end
                s_refill: begin
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                    end
                    if (r_beat) begin
                        bcnt <= bcnt + 1'b1;
                    end
                    if (refill_end) begin
                        state <= s_idle;
                        bcnt  <= '0;
                    end
                end
                s_uncached: begin
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                    end
                    if (awvalid && awready) begin
                        awvalid <= 1'b0;
                        wvalid  <= 1'b1;
                    end
                    if (wvalid && wready) begin
                        wvalid <= 1'b0;
                    end
                    if ((r_beat && rlast) || (bvalid && bready)) begin
                        state <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    // victim and returned word
    always_ff @(posedge clk) begin
        if (state == s_lookup) begin
            victim_q <= victim;
        end
        if (state == s_refill && r_beat && bcnt == req_addr.f.word) begin
            saved_rdata <= refill_word;
        end else if (uncached && r_beat) begin
            saved_rdata <= rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (store_hit) begin
                dirty_q[req_addr.f.index][hit_way] <= 1'b1;
            end
            if (refill_end) begin
                valid_q[req_addr.f.index][victim_q] <= 1'b1;
                dirty_q[req_addr.f.index][victim_q] <= is_store;  // store merged during refill
            end
        end
    end

    plru_tree plru_i (
        .clk       (clk),
        .rst       (rst),
        .index     (req_addr.f.index),
        .touch     (hit_acc || refill_end),
        .touch_way (refill_end ? victim_q : hit_way),
        .victim    (victim)
    );

    for (genvar w = 0; w < way_num; w++) begin : g_way
        d_tag_ram tag_ram_i (
            .clk   (clk),
            .we    (way_tag_we[w]),
            .waddr (req_addr.f.index),
            .wtag  (req_addr.f.tag),
            .re    (ram_re),
            .raddr (exe_addr.f.index),
            .rtag  (rtag[w])
        );

        d_data_bank bank_i (
            .clk   (clk),
            .wbe   (way_wbe[w]),
            .wword (wr_word),
            .waddr (req_addr.f.index),
            .wdata (wr_data),
            .re    (ram_re),
            .raddr (exe_addr.f.index),
            .rline (rline[w])
        );
    end

endmodule

`default_nettype wire

//--- design/dcache_top.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_top (
    input  wire         clk,
    input  wire         rst,
    // cpu execute stage
    input  wire         mem_req_e,
    input  wire [31:0]  mem_addr_e,
    // cpu memory stage
    input  wire         data_en,
    input  wire [31:0]  data_addr,
    input  wire [3:0]   data_wen,
    input  wire [31:0]  data_wdata,
    input  wire         no_cache,
    output logic [31:0] data_rdata,
    output logic        stall,
    // memory read side
    output logic [31:0] araddr,
    output logic [7:0]  arlen,
    output logic        arvalid,
    input  wire         arready,
    input  wire [31:0]  rdata,
    input  wire         rvalid,
    input  wire         rlast,
    output logic        rready,
    // memory write side
    output logic [31:0] awaddr,
    output logic [7:0]  awlen,
    output logic        awvalid,
    input  wire         awready,
    output logic [31:0] wdata,
    output logic [3:0]  wstrb,
    output logic        wlast,
    output logic        wvalid,
    input  wire         wready,
    input  wire         bvalid,
    output logic        bready
);

    // port names match one to one
    d_cache cache_i (.*);

endmodule

`default_nettype wire

//--- verification/axi_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module axi_mem_model (
    input  wire         clk,
    input  wire         rst,
    input  wire         hold,       // holds every ready low for a cycle
    // read side
    input  wire  [31:0] araddr,
    input  wire  [7:0]  arlen,
    input  wire         arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic        rvalid,
    output logic        rlast,
    input  wire         rready,
    // write side
    input  wire  [31:0] awaddr,
    input  wire         awvalid,
    output logic        awready,
    input  wire  [31:0] wdata,
    input  wire  [3:0]  wstrb,
    input  wire         wlast,
    input  wire         wvalid,
    output logic        wready,
    output logic        bvalid,
    input  wire         bready
);
    localparam int mem_words = 4096;

    logic [31:0] mem [mem_words];
    logic        rd_busy, wr_busy;
    logic [31:0] rd_addr, wr_addr;
    logic [7:0]  rd_left;

    assign arready = !rd_busy && !hold;
    assign awready = !wr_busy && !hold;
    assign wready  = wr_busy && !bvalid && !hold;

    always @(posedge clk) begin
        if (rst) begin
            rd_busy <= 1'b0;
            wr_busy <= 1'b0;
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
            bvalid  <= 1'b0;
            for (int i = 0; i < mem_words; i++) begin
                mem[i] <= (i * 32'h9e3779b1) ^ 32'h5bd1e995;   // every address bit counts
            end
        end else begin
            if (arvalid && arready) begin
                rd_busy <= 1'b1;
                rd_addr <= araddr;
                rd_left <= arlen;
            end
            if (rd_busy && !rvalid && !hold) begin
                rvalid <= 1'b1;
                rdata  <= mem[rd_addr[13:2]];
                rlast  <= (rd_left == 8'd0);
            end
            if (rvalid && rready) begin
                rvalid  <= 1'b0;
                rd_addr <= rd_addr + 32'd4;
                rd_left <= rd_left - 8'd1;
                if (rlast) begin
                    rd_busy <= 1'b0;
                end
            end
            if (awvalid && awready) begin
                wr_busy <= 1'b1;
                wr_addr <= awaddr;
            end
            if (wvalid && wready) begin
                for (int b = 0; b < 4; b++) begin
                    if (wstrb[b]) begin
                        mem[wr_addr[13:2]][b*8 +: 8] <= wdata[b*8 +: 8];
                    end
                end
                wr_addr <= wr_addr + 32'd4;
                if (wlast) begin
                    bvalid <= 1'b1;
                end
            end
            if (bvalid && bready) begin
                bvalid  <= 1'b0;
                wr_busy <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/tb_dcache.sv
`timescale 1ns/1ns
`default_nettype none

module tb_dcache;
    localparam int n_access    = 450;
    localparam int worst_miss  = 120;      // cycles for write-back plus refill under back-pressure
    localparam int wait_limit  = 400;

    logic clk, rst, mem_req_e, data_en, no_cache, stall, mem_hold, random_ready;
    logic [31:0] mem_addr_e, data_addr, data_wdata, data_rdata;
    logic [3:0]  data_wen, wstrb;
    logic [31:0] araddr, rdata, awaddr, wdata;
    logic [7:0]  arlen, awlen;
    logic arvalid, arready, rvalid, rlast, rready;
    logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;

    logic [31:0] seed, hold_seed;
    logic [31:0] ref_mem [4096];
    logic        m_valid [16][4];
    logic        m_dirty [16][4];
    logic [23:0] m_tag [16][4];
    logic [2:0]  m_plru [16];
    int          ar_count, aw_count;
    logic [31:0] last_araddr, last_awaddr;
    logic [7:0]  last_arlen, last_awlen;
    logic [3:0]  last_wstrb;

    dcache_top dut_i (.*);

    axi_mem_model mem_i (.hold(mem_hold), .*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function logic [31:0] next_rand();
        seed = lcg(seed);
        return seed;
    endfunction

    function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] nw,
                                          input logic [3:0] wen);
        logic [31:0] r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (wen[b]) r[b*8 +: 8] = nw[b*8 +: 8];
        end
        return r;
    endfunction

    // tree pseudo-LRU model
    function automatic logic [1:0] plru_victim(input logic [2:0] t);
        logic [1:0] v;
        v[1] = t[0];                // root bit names the half
        if (t[0]) begin
            v[0] = t[2];
        end else begin
            v[0] = t[1];
        end
        return v;
    endfunction

    function automatic logic [2:0] plru_touch(input logic [2:0] t, input logic [1:0] w);
        logic [2:0] r;
        r = t;
        r[0] = ~w[1];
        if (w[1]) r[2] = ~w[0];
        else r[1] = ~w[0];
        return r;
    endfunction

    task automatic abort(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort($sformatf("Fail %0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    // handshake monitor
    always @(posedge clk) begin
        if (arvalid && arready) begin
            ar_count    <= ar_count + 1;
            last_araddr <= araddr;
            last_arlen  <= arlen;
        end
        if (awvalid && awready) begin
            aw_count    <= aw_count + 1;
            last_awaddr <= awaddr;
            last_awlen  <= awlen;
        end
        if (wvalid && wready) last_wstrb <= wstrb;
    end

    always @(posedge clk) begin
        hold_seed = lcg(hold_seed);
        mem_hold <= random_ready && (hold_seed[31:30] == 2'b00);
    end

    // execute stage, then memory stage until stall drops
    task automatic access(input logic [31:0] addr, input logic [3:0] wen,
                          input logic [31:0] wd, input logic nc, output logic [31:0] rd);
        int n;
        @(posedge clk);
        mem_req_e  <= 1'b1;
        mem_addr_e <= addr;
        @(posedge clk);
        mem_req_e  <= 1'b0;
        data_en    <= 1'b1;
        data_addr  <= addr;
        data_wen   <= wen;
        data_wdata <= wd;
        no_cache   <= nc;
        @(negedge clk);
        n = 0;
        while (stall) begin
            n++;
            if (n > wait_limit) abort("stall never dropped, access timed out");
            @(negedge clk);
        end
        rd = data_rdata;
        @(posedge clk);
        data_en  <= 1'b0;
        data_wen <= 4'h0;
        no_cache <= 1'b0;
    endtask

    task automatic cached(input logic [31:0] addr, input logic [3:0] wen, input logic [31:0] wd);
        logic [3:0]  set;
        logic [1:0]  way;
        logic        hit, exp_wb;
        logic [31:0] wb_addr, rd;
        int          ar0, aw0;
        set = addr[7:4];
        hit = 1'b0;
        way = 2'd0;
        for (int w = 0; w < 4; w++) begin
            if (m_valid[set][w] && m_tag[set][w] == addr[31:8]) begin
                hit = 1'b1;
                way = 2'(w);
            end
        end
        if (!hit) way = plru_victim(m_plru[set]);
        exp_wb  = !hit && m_valid[set][way] && m_dirty[set][way];
        wb_addr = {m_tag[set][way], set, 4'h0};
        ar0 = ar_count;
        aw0 = aw_count;
        access(addr, wen, wd, 1'b0, rd);
        if (wen == 4'h0) check("load data", rd, ref_mem[addr[13:2]]);
        else ref_mem[addr[13:2]] = merge(ref_mem[addr[13:2]], wd, wen);
        if (hit) begin
            check("ar count on hit", ar_count, ar0);
            if (wen != 4'h0) m_dirty[set][way] = 1'b1;
        end else begin
            check("ar count on miss", ar_count, ar0 + 1);
            check("refill araddr", last_araddr, {addr[31:4], 4'h0});
            check("refill arlen", 32'(last_arlen), 32'd3);
            check("aw count on miss", aw_count, aw0 + int'(exp_wb));
            if (exp_wb) begin
                check("write-back awaddr", last_awaddr, wb_addr);
                check("write-back awlen", 32'(last_awlen), 32'd3);
            end
            m_valid[set][way] = 1'b1;
            m_tag[set][way]   = addr[31:8];
            m_dirty[set][way] = (wen != 4'h0);
        end
        m_plru[set] = plru_touch(m_plru[set], way);
    endtask

    task automatic uncached(input logic [31:0] addr, input logic [3:0] wen, input logic [31:0] wd);
        logic [31:0] rd;
        access(addr, wen, wd, 1'b1, rd);
        if (wen == 4'h0) begin
            check("uncached load data", rd, ref_mem[addr[13:2]]);
            check("uncached araddr", last_araddr, addr);
            check("uncached arlen", 32'(last_arlen), 32'd0);
        end else begin
            ref_mem[addr[13:2]] = merge(ref_mem[addr[13:2]], wd, wen);
            check("uncached awlen", 32'(last_awlen), 32'd0);
            check("uncached wstrb", 32'(last_wstrb), 32'(wen));
            check("memory after uncached store", mem_i.mem[addr[13:2]], ref_mem[addr[13:2]]);
        end
    endtask

    // stall and the memory-port valids idle once reset is released
    task automatic reset_state_test();
        @(negedge clk);
        check("stall after reset", 32'(stall), 32'd0);
        check("arvalid after reset", 32'(arvalid), 32'd0);
        check("awvalid after reset", 32'(awvalid), 32'd0);
        check("wvalid after reset", 32'(wvalid), 32'd0);
    endtask

    task automatic line_fill_test();
        for (int w = 0; w < 4; w++) cached(32'h110 + 32'(w * 4), 4'h0, 32'h0);
    endtask

    task automatic merge_test();
        cached(32'h114, 4'b0101, 32'haabbccdd);
        cached(32'h114, 4'h0, 32'h0);
        cached(32'h218, 4'b1100, 32'h11223344);    // store miss
        cached(32'h218, 4'h0, 32'h0);
    endtask

    task automatic eviction_test();
        for (int t = 1; t <= 4; t++) cached(32'(t << 8) | 32'h54, 4'hf, 32'(t) * 32'h01010101);
        cached(32'h554, 4'h0, 32'h0);
        check("evicted word in memory", mem_i.mem[32'h154 >> 2], ref_mem[32'h154 >> 2]);
    endtask

    task automatic uncached_test();
        uncached(32'h394, 4'h0, 32'h0);
        uncached(32'h394, 4'b0110, 32'hcafef00d);
        cached(32'h394, 4'h0, 32'h0);
    endtask

    task automatic random_test();
        logic [31:0] r, addr;
        random_ready = 1'b1;
        for (int i = 0; i < 300; i++) begin
            r    = next_rand();
            addr = {21'h0, r[10:8], 2'b00, 2'(r[17:16] % 3), r[3:2], 2'b00};
            if (r[20]) cached(addr, r[27:24] == 4'h0 ? 4'hf : r[27:24], next_rand());
            else cached(addr, 4'h0, 32'h0);
        end
        for (int s = 0; s < 3; s++) begin
            for (int t = 0; t < 8; t++) begin
                for (int w = 0; w < 4; w++) cached(32'((t << 8) | (s << 4) | (w << 2)), 4'h0, 0);
            end
        end
        random_ready = 1'b0;
    endtask

    initial begin
        #(n_access * worst_miss * 8);
        abort("watchdog expired before the tests finished");
    end

    initial begin
        seed = 32'd33;
        hold_seed = 32'd33;
        rst = 1'b1;
        random_ready = 1'b0;
        mem_hold = 1'b0;
        {mem_req_e, data_en, no_cache} = 3'b000;
        {mem_addr_e, data_addr, data_wdata} = '0;
        data_wen = 4'h0;
        ar_count = 0;
        aw_count = 0;
        for (int i = 0; i < 4096; i++) ref_mem[i] = (i * 32'h9e3779b1) ^ 32'h5bd1e995;
        for (int s = 0; s < 16; s++) begin
            m_plru[s] = 3'b000;
            for (int w = 0; w < 4; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_tag[s][w]   = '0;
            end
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        reset_state_test();
        line_fill_test();
        merge_test();
        eviction_test();
        uncached_test();
        random_test();
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
common/dcache_pkg.sv
d_cache/d_tag_ram.sv
d_cache/d_data_bank.sv
d_cache/plru_tree.sv
d_cache/d_cache.sv
design/dcache_top.sv
verification/axi_mem_model.sv
verification/tb_dcache.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
